// File: hdl/sparcIsaPkg.sv
package sparcIsaPkg;

	typedef logic [31:0] instrWordT;
	typedef logic [4:0]  regAddrT;
	typedef logic [5:0]  op3T;

	// Kinds of instruction the control unit handles
	typedef enum logic [2:0]
	{
		ClassArith,
		ClassSethi,
		ClassLoad,
		ClassStore,
		ClassOther // Straight to PC advance
	} instrClassT;

	// Field positions in the instruction word
	localparam int OpHi    = 31;
	localparam int OpLo    = 30;
	localparam int RdHi    = 29;
	localparam int RdLo    = 25;
	localparam int Op2Hi   = 24; // Format 2 only
	localparam int Op2Lo   = 22;
	localparam int Op3Hi   = 24;
	localparam int Op3Lo   = 19;
	localparam int Rs1Hi   = 18;
	localparam int Rs1Lo   = 14;
	localparam int Rs2Hi   = 4;
	localparam int Rs2Lo   = 0;
	localparam int ImmBit  = 13; // i bit, operand B from simm13
	localparam int FlagBit = 23; // op3 bit 4, cc update

	// op field
	localparam logic [1:0] OpFmt2  = 2'b00; // Sethi and branches
	localparam logic [1:0] OpCall  = 2'b01;
	localparam logic [1:0] OpArith = 2'b10;
	localparam logic [1:0] OpMem   = 2'b11;

	localparam logic [2:0] Op2Sethi = 3'b100;

	// Load op3 codes
	localparam op3T Op3Ld   = 6'b000000; // Word
	localparam op3T Op3Ldub = 6'b000001;
	localparam op3T Op3Lduh = 6'b000010;
	localparam op3T Op3Ldsb = 6'b001001;
	localparam op3T Op3Ldsh = 6'b001010;

	// Store op3 codes
	localparam op3T Op3Stb = 6'b000101;
	localparam op3T Op3Sth = 6'b000110;
	localparam op3T Op3St  = 6'b000100;

endpackage

// File: hdl/ctrlPkg.sv
package ctrlPkg;

	// Listed in numeric order, StPcLoad is the highest code
	typedef enum logic [5:0]
	{
		StReset,      // Clear PC and PSR
		StNpcSetup,   // ALU = 0 + 4
		StNpcLoad,
		StFetchAddr,  // PC into MAR
		StFetchWait,  // RAM read until mfc
		StIrLoad,
		StDecode,
		StArithOp,    // A operand and ALU op
		StArithImm,
		StArithReg,
		StArithImmWr,
		StArithRegWr,
		StSethiSetup,
		StSethiWr,
		StLoadOp,     // Address base rs1
		StLoadImm,    // MAR load, imm offset
		StLoadReg,    // MAR load, rs2 offset
		StLoadWait,
		StLoadMdr,
		StLoadWr,
		StStoreOp,
		StStoreImm,
		StStoreReg,
		StStoreMdr,   // rd through ALU into MDR
		StStoreWait,
		StPcSetup,    // NPC + 4
		StPcLoad      // PC <- NPC, NPC <- NPC + 4
	} ctrlStateT;

	typedef logic [5:0] aluOpT;
	localparam aluOpT AluAdd = 6'b000000;

	typedef enum logic [1:0]
	{
		AluAReg  = 2'b00, // Register file port A
		AluAZero = 2'b01,
		AluANpc  = 2'b10
	} aluASelT;

	typedef enum logic [2:0]
	{
		AluBReg  = 3'b000, // Register file port B
		AluBExt  = 3'b001,
		AluBMdr  = 3'b010,
		AluBPc   = 3'b011,
		AluBFour = 3'b110
	} aluBSelT;

	typedef enum logic [1:0] {PcInNpc = 2'b00} pcInSelT;

	typedef enum logic [1:0] {PsrFromAlu = 2'b00} psrSelT; // ALU condition codes

	typedef enum logic [2:0]
	{
		ExtSimm13 = 3'b000, // Sign extend bits 12..0
		ExtImm22  = 3'b100  // imm22 into the upper bits
	} extSelT;

	// MDR input mux
	localparam logic MdrFromAlu = 1'b0;
	localparam logic MdrFromRam = 1'b1;

endpackage

// File: hdl/instrDecoder.sv
module instrDecoder
	import sparcIsaPkg::*;
(
	input  instrWordT  irOut,
	output instrClassT instrClass,
	output logic       isImm,
	output logic       setsFlags,
	output regAddrT    rd,
	output regAddrT    rs1,
	output regAddrT    rs2,
	output op3T        op3
);

	logic [1:0] op;
	logic [2:0] op2;

	assign op  = irOut[OpHi:OpLo];
	assign op2 = irOut[Op2Hi:Op2Lo]; // Overlaps op3, meaningful for op 00 only

	// Register and operand fields, the only place the word is indexed
	assign rd        = irOut[RdHi:RdLo];
	assign rs1       = irOut[Rs1Hi:Rs1Lo];
	assign rs2       = irOut[Rs2Hi:Rs2Lo];
	assign op3       = irOut[Op3Hi:Op3Lo];
	assign isImm     = irOut[ImmBit];
	assign setsFlags = irOut[FlagBit];

	always_comb
	begin
		instrClass = ClassOther; // Branches, call, unknown codes
		case (op)
			OpFmt2:
			begin
				if (op2 == Op2Sethi)
					instrClass = ClassSethi;
			end
			OpCall:
				instrClass = ClassOther; // Call not handled here
			OpArith:
				instrClass = ClassArith;
			OpMem:
			begin
				// Doubles, swap and alternate space fall through to other
				if (op3 inside {Op3Ld, Op3Ldub, Op3Lduh, Op3Ldsb, Op3Ldsh})
					instrClass = ClassLoad;
				else if (op3 inside {Op3Stb, Op3Sth, Op3St})
					instrClass = ClassStore;
			end
			default:
				instrClass = ClassOther;
		endcase
	end

endmodule

// File: hdl/ctrlSequencer.sv
module ctrlSequencer
	import sparcIsaPkg::*;
	import ctrlPkg::*;
(
	input  logic       Clk,
	input  logic       RESET,
	input  logic       mfc,        // Memory function complete
	input  instrClassT instrClass,
	input  logic       isImm,
	output ctrlStateT  state
);

	ctrlStateT nextState;
	logic      memWait; // In a state that holds ramEnable

	assign memWait = state inside {StFetchWait, StLoadWait, StStoreWait};

	always_ff @(posedge Clk)
	begin
		if (RESET)
			state <= StReset;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state;
		case (state)
			// Reset init and NPC = 4
			StReset:      nextState = StNpcSetup;
			StNpcSetup:   nextState = StNpcLoad;
			StNpcLoad:    nextState = StFetchAddr;

			// Fetch
			StFetchAddr:  nextState = StFetchWait;
			StFetchWait:
			begin
				if (mfc)
					nextState = StIrLoad;
			end
			StIrLoad:     nextState = StDecode;

			StDecode:
			begin
				case (instrClass)
					ClassArith: nextState = StArithOp;
					ClassSethi: nextState = StSethiSetup;
					ClassLoad:  nextState = StLoadOp;
					ClassStore: nextState = StStoreOp;
					default:    nextState = StPcSetup; // Nothing to execute
				endcase
			end

			// Arith and logic
			StArithOp:    nextState = isImm ? StArithImm : StArithReg;
			StArithImm:   nextState = StArithImmWr;
			StArithReg:   nextState = StArithRegWr;
			StArithImmWr: nextState = StPcSetup;
			StArithRegWr: nextState = StPcSetup;

			StSethiSetup: nextState = StSethiWr;
			StSethiWr:    nextState = StPcSetup;

			// Load
			StLoadOp:     nextState = isImm ? StLoadImm : StLoadReg;
			StLoadImm:    nextState = StLoadWait;
			StLoadReg:    nextState = StLoadWait;
			StLoadWait:
			begin
				if (mfc)
					nextState = StLoadMdr;
			end
			StLoadMdr:    nextState = StLoadWr;
			StLoadWr:     nextState = StPcSetup;

			// Store
			StStoreOp:    nextState = isImm ? StStoreImm : StStoreReg;
			StStoreImm:   nextState = StStoreMdr;
			StStoreReg:   nextState = StStoreMdr;
			StStoreMdr:   nextState = StStoreWait;
			StStoreWait:
			begin
				if (mfc)
					nextState = StPcSetup;
			end

			// Common PC advance
			StPcSetup:    nextState = StPcLoad;
			StPcLoad:     nextState = StFetchAddr;

			default:      nextState = StReset; // Unused code, restart
		endcase
	end

	// Only declared codes ever reach the register
	assert property (@(posedge Clk) disable iff (RESET)
		!$isunknown(state) && (state <= StPcLoad))
		else $error("Undeclared state code %0d", state);

	// A memory wait is held across every cycle without mfc
	assert property (@(posedge Clk) disable iff (RESET)
		(memWait && !mfc) |=> (state == $past(state)))
		else $error("Memory wait state left without mfc");

endmodule

// File: hdl/ctrlSignalGen.sv
module ctrlSignalGen
	import sparcIsaPkg::*;
	import ctrlPkg::*;
(
	input  ctrlStateT state,
	input  logic      setsFlags,
	input  regAddrT   rd,
	input  regAddrT   rs1,
	input  regAddrT   rs2,
	input  op3T       op3,
	output logic      irEnable,
	output logic      npcEnable,
	output logic      pcEnable,
	output logic      mdrEnable,
	output logic      marEnable,
	output logic      regFileWrite,
	output logic      ramEnable,
	output logic      psrEnable,
	output logic      pcClr,
	output logic      psrClr,
	output extSelT    extenderSelect,
	output pcInSelT   pcInMuxSelect,
	output aluASelT   aluAMuxSelect,
	output psrSelT    psrMuxSelect,
	output aluBSelT   aluBMuxSelect,
	output logic      mdrMuxSelect,
	output regAddrT   inPc,
	output regAddrT   inPa,
	output regAddrT   inPb,
	output aluOpT     aluOp,
	output op3T       ramOpCode
);

	always_comb
	begin
		// Strobes low, selects and addresses zero
		irEnable       = 1'b0;
		npcEnable      = 1'b0;
		pcEnable       = 1'b0;
		mdrEnable      = 1'b0;
		marEnable      = 1'b0;
		regFileWrite   = 1'b0;
		ramEnable      = 1'b0;
		psrEnable      = 1'b0;
		pcClr          = 1'b0;
		psrClr         = 1'b0;
		extenderSelect = ExtSimm13;
		pcInMuxSelect  = PcInNpc;
		aluAMuxSelect  = AluAReg;
		psrMuxSelect   = PsrFromAlu;
		aluBMuxSelect  = AluBReg;
		mdrMuxSelect   = MdrFromAlu;
		inPc           = '0;
		inPa           = '0;
		inPb           = '0;
		aluOp          = AluAdd;
		ramOpCode      = Op3Ld;
		case (state)
			StReset:
			begin
				pcClr  = 1'b1;
				psrClr = 1'b1;
			end
			StNpcSetup, StNpcLoad:
			begin
				aluAMuxSelect = AluAZero; // 0 + 4
				aluBMuxSelect = AluBFour;
				npcEnable     = (state == StNpcLoad);
			end
			StFetchAddr:
			begin
				aluAMuxSelect = AluAZero; // PC passes the ALU
				aluBMuxSelect = AluBPc;
				marEnable     = 1'b1;
			end
			StFetchWait:
				ramEnable = 1'b1; // Word read, held until mfc
			StIrLoad:
				irEnable = 1'b1;
			StDecode:
				aluOp = AluAdd; // Idle cycle while IR settles
			StArithOp, StArithImm, StArithReg, StArithImmWr, StArithRegWr:
			begin
				inPa  = rs1;
				inPc  = rd;
				aluOp = op3; // op3 doubles as the ALU code
				if (state inside {StArithImm, StArithImmWr})
					aluBMuxSelect = AluBExt; // simm13
				else if (state inside {StArithReg, StArithRegWr})
					inPb = rs2;
				regFileWrite = (state inside {StArithImmWr, StArithRegWr});
				psrEnable    = regFileWrite && setsFlags; // cc forms only
			end
			StSethiSetup, StSethiWr:
			begin
				extenderSelect = ExtImm22;
				aluAMuxSelect  = AluAZero;
				aluBMuxSelect  = AluBExt;
				inPc           = rd;
				regFileWrite   = (state == StSethiWr);
			end
			StLoadOp, StLoadImm, StLoadReg, StStoreOp, StStoreImm, StStoreReg:
			begin
				inPa      = rs1; // Address = rs1 + offset
				ramOpCode = op3;
				if (state inside {StLoadImm, StStoreImm})
					aluBMuxSelect = AluBExt;
				else if (state inside {StLoadReg, StStoreReg})
					inPb = rs2;
				marEnable = !(state inside {StLoadOp, StStoreOp});
			end
			StLoadWait, StLoadMdr:
			begin
				ramOpCode    = op3;
				mdrMuxSelect = MdrFromRam;
				ramEnable    = (state == StLoadWait);
				mdrEnable    = (state == StLoadMdr);
			end
			StLoadWr:
			begin
				aluAMuxSelect = AluAZero; // MDR through the ALU
				aluBMuxSelect = AluBMdr;
				inPc          = rd;
				regFileWrite  = 1'b1;
			end
			StStoreMdr:
			begin
				inPa      = rd; // rd + r0 into MDR
				ramOpCode = op3;
				mdrEnable = 1'b1;
			end
			StStoreWait:
			begin
				ramOpCode = op3;
				ramEnable = 1'b1;
			end
			StPcSetup, StPcLoad:
			begin
				aluAMuxSelect = AluANpc; // NPC + 4 for next NPC
				aluBMuxSelect = AluBFour;
				pcEnable      = (state == StPcLoad);
				npcEnable     = (state == StPcLoad);
			end
			default:
			begin
				pcClr  = 1'b0;
				psrClr = 1'b0;
			end
		endcase
	end

	// MAR takes the ALU while RAM would read it
	assert final (!(marEnable && ramEnable))
		else $error("marEnable and ramEnable high together");

	assert final ($onehot0({regFileWrite, marEnable, mdrEnable}))
		else $error("More than one write strobe in state %0d", state);

endmodule

// File: hdl/controlUnit.sv
module controlUnit
	import sparcIsaPkg::*;
	import ctrlPkg::*;
(
	input  logic      Clk,
	input  logic      RESET,
	input  instrWordT irOut,
	input  logic      mfc,
	output logic      irEnable,
	output logic      npcEnable,
	output logic      pcEnable,
	output logic      mdrEnable,
	output logic      marEnable,
	output logic      regFileWrite,
	output logic      ramEnable,
	output logic      psrEnable,
	output logic      pcClr,
	output logic      psrClr,
	output extSelT    extenderSelect,
	output pcInSelT   pcInMuxSelect,
	output aluASelT   aluAMuxSelect,
	output psrSelT    psrMuxSelect,
	output aluBSelT   aluBMuxSelect,
	output logic      mdrMuxSelect,
	output regAddrT   inPc,
	output regAddrT   inPa,
	output regAddrT   inPb,
	output aluOpT     aluOp,
	output op3T       ramOpCode
);

	instrClassT instrClass;
	logic       isImm;
	logic       setsFlags;
	regAddrT    rd;
	regAddrT    rs1;
	regAddrT    rs2;
	op3T        op3;
	ctrlStateT  state;

	// IR fields, combinational
	instrDecoder i_instrDecoder
	(
		.irOut      (irOut),
		.instrClass (instrClass),
		.isImm      (isImm),
		.setsFlags  (setsFlags),
		.rd         (rd),
		.rs1        (rs1),
		.rs2        (rs2),
		.op3        (op3)
	);

	ctrlSequencer i_ctrlSequencer
	(
		.Clk        (Clk),
		.RESET      (RESET),
		.mfc        (mfc),
		.instrClass (instrClass),
		.isImm      (isImm),
		.state      (state)
	);

	// Moore outputs from state plus IR fields
	ctrlSignalGen i_ctrlSignalGen
	(
		.state          (state),
		.setsFlags      (setsFlags),
		.rd             (rd),
		.rs1            (rs1),
		.rs2            (rs2),
		.op3            (op3),
		.irEnable       (irEnable),
		.npcEnable      (npcEnable),
		.pcEnable       (pcEnable),
		.mdrEnable      (mdrEnable),
		.marEnable      (marEnable),
		.regFileWrite   (regFileWrite),
		.ramEnable      (ramEnable),
		.psrEnable      (psrEnable),
		.pcClr          (pcClr),
		.psrClr         (psrClr),
		.extenderSelect (extenderSelect),
		.pcInMuxSelect  (pcInMuxSelect),
		.aluAMuxSelect  (aluAMuxSelect),
		.psrMuxSelect   (psrMuxSelect),
		.aluBMuxSelect  (aluBMuxSelect),
		.mdrMuxSelect   (mdrMuxSelect),
		.inPc           (inPc),
		.inPa           (inPa),
		.inPb           (inPb),
		.aluOp          (aluOp),
		.ramOpCode      (ramOpCode)
	);

endmodule

// File: tb/ctrlChecker.sv
module ctrlChecker
	import sparcIsaPkg::*;
	import ctrlPkg::*;
(
	input  logic      Clk,
	input  logic      RESET,
	input  instrWordT irOut,
	input  logic      mfc,
	input  logic      irEnable,
	input  logic      npcEnable,
	input  logic      pcEnable,
	input  logic      mdrEnable,
	input  logic      marEnable,
	input  logic      regFileWrite,
	input  logic      ramEnable,
	input  logic      psrEnable,
	input  logic      pcClr,
	input  logic      psrClr,
	input  extSelT    extenderSelect,
	input  pcInSelT   pcInMuxSelect,
	input  aluASelT   aluAMuxSelect,
	input  psrSelT    psrMuxSelect,
	input  aluBSelT   aluBMuxSelect,
	input  logic      mdrMuxSelect,
	input  regAddrT   inPc,
	input  regAddrT   inPa,
	input  regAddrT   inPb,
	input  aluOpT     aluOp,
	input  op3T       ramOpCode,
	output int        testCount,
	output int        errCount
);

	// Kind field of an event word
	localparam logic [3:0] KindNone    = 4'd0;
	localparam logic [3:0] KindReg     = 4'd1;
	localparam logic [3:0] KindRegPsr  = 4'd2; // Register write with flag update
	localparam logic [3:0] KindMar     = 4'd3;
	localparam logic [3:0] KindMdr     = 4'd4;
	localparam logic [3:0] KindRam     = 4'd5; // First cycle of a RAM access
	localparam logic [3:0] KindPcAdv   = 4'd6;
	localparam logic [3:0] KindPsrOnly = 4'd7;

	// Field masks of an event word with inPb and selects above the kind
	localparam logic [43:0] PbM   = 44'hF80_0000_0000; // inPb
	localparam logic [43:0] ASelM = 44'h060_0000_0000;
	localparam logic [43:0] MdrSM = 44'h010_0000_0000;
	localparam logic [43:0] PcInM = 44'h00C_0000_0000;
	localparam logic [43:0] PsrSM = 44'h003_0000_0000;
	localparam logic [43:0] KindM = 44'h000_F000_0000;
	localparam logic [43:0] PcM   = 44'h000_0F80_0000; // inPc
	localparam logic [43:0] PaM   = 44'h000_007C_0000; // inPa
	localparam logic [43:0] AluM  = 44'h000_0003_F000;
	localparam logic [43:0] RamM  = 44'h000_0000_0FC0;
	localparam logic [43:0] BSelM = 44'h000_0000_0038;
	localparam logic [43:0] ESelM = 44'h000_0000_0007;

	logic [3:0]  obsKind;
	logic [43:0] obsWord;
	logic        ramPrev;
	logic        anyEnable;
	logic        startup;   // Between reset release and first fetch
	logic        sawClear;
	logic        waitRam;   // Fetch wait with ramEnable held
	logic        mfcSeen;
	logic        recording; // Between irEnable and PC advance
	logic        testErr;
	int          npcPulses;
	int          idx;
	instrWordT   word;
	logic [87:0] expected;

	// Expected {mask, value} of event idx after irEnable
	// All zero past the last event of the word
	function automatic logic [87:0] refEvent(input instrWordT w, input int idx);
		logic [43:0] ev [0:5];
		logic [43:0] mk [0:5];
		int          n;
		logic [1:0]  op;
		op3T         code;
		regAddrT     rdF;
		regAddrT     rs1F;
		regAddrT     pbF;
		logic [2:0]  bSel;
		op   = w[OpHi:OpLo];
		code = w[Op3Hi:Op3Lo];
		rdF  = w[RdHi:RdLo];
		rs1F = w[Rs1Hi:Rs1Lo];
		bSel = w[ImmBit] ? AluBExt : AluBReg; // Operand B from i bit
		pbF  = w[ImmBit] ? 5'd0 : w[Rs2Hi:Rs2Lo]; // Port B address idle for simm13
		n    = 0;
		if (op == OpArith)
		begin
			ev[0] = {pbF, AluAReg, 3'd0, PsrFromAlu, w[FlagBit] ? KindRegPsr : KindReg,
				rdF, 5'd0, code, 6'd0, bSel, 3'd0};
			mk[0] = PbM | ASelM | PsrSM | KindM | PcM | AluM | BSelM;
			n     = 1;
		end
		else if (op == OpFmt2 && w[Op2Hi:Op2Lo] == Op2Sethi)
		begin
			ev[0] = {5'd0, AluAZero, 5'd0, KindReg, rdF, 20'd0, ExtImm22};
			mk[0] = ASelM | KindM | PcM | ESelM;
			n     = 1;
		end
		else if (op == OpMem && (code inside {Op3Ld, Op3Ldub, Op3Lduh, Op3Ldsb, Op3Ldsh}))
		begin
			ev[0] = {pbF, AluAReg, 5'd0, KindMar, 5'd0, rs1F, AluAdd, 6'd0, bSel, 3'd0};
			mk[0] = PbM | ASelM | KindM | PaM | AluM | BSelM; // rs1 + offset
			ev[1] = {12'd0, KindRam, 16'd0, code, 6'd0};
			mk[1] = KindM | RamM;
			ev[2] = {7'd0, MdrFromRam, 4'd0, KindMdr, 28'd0};
			mk[2] = MdrSM | KindM;
			ev[3] = {5'd0, AluAZero, 5'd0, KindReg, rdF, 23'd0}; // MDR through the ALU
			mk[3] = ASelM | KindM | PcM;
			n     = 4;
		end
		else if (op == OpMem && (code inside {Op3Stb, Op3Sth, Op3St}))
		begin
			ev[0] = {pbF, AluAReg, 5'd0, KindMar, 5'd0, rs1F, AluAdd, 6'd0, bSel, 3'd0};
			mk[0] = PbM | ASelM | KindM | PaM | AluM | BSelM;
			ev[1] = {5'd0, AluAReg, MdrFromAlu, 4'd0, KindMdr, 5'd0, rdF, 18'd0};
			mk[1] = PbM | ASelM | MdrSM | KindM | PaM; // Store data from rd
			ev[2] = {12'd0, KindRam, 16'd0, code, 6'd0};
			mk[2] = KindM | RamM;
			n     = 3;
		end
		// Every path closes with the joint PC/NPC load
		ev[n] = {5'd0, AluANpc, 1'b0, PcInNpc, 2'd0, KindPcAdv, 22'd0, AluBFour, 3'd0};
		mk[n] = ASelM | PcInM | KindM | BSelM;
		n++;
		return (idx < n) ? {mk[idx], ev[idx]} : 88'd0;
	endfunction

	assign anyEnable = irEnable || npcEnable || pcEnable || mdrEnable || marEnable
		|| regFileWrite || ramEnable || psrEnable;

	// One event per cycle with the highest priority first
	always_comb
	begin
		obsKind = KindNone;
		if (pcEnable || npcEnable)
			obsKind = KindPcAdv;
		else if (regFileWrite)
			obsKind = psrEnable ? KindRegPsr : KindReg;
		else if (psrEnable)
			obsKind = KindPsrOnly;
		else if (marEnable)
			obsKind = KindMar;
		else if (mdrEnable)
			obsKind = KindMdr;
		else if (ramEnable && !ramPrev)
			obsKind = KindRam;
		obsWord = {inPb, aluAMuxSelect, mdrMuxSelect, pcInMuxSelect, psrMuxSelect,
			obsKind, inPc, inPa, aluOp, ramOpCode, aluBMuxSelect, extenderSelect};
	end

	task automatic valueError(input string msg);
		$display("ERR %0t: %s", $time, msg);
		errCount++;
		testErr = 1'b1;
	endtask

	task automatic flowError(input string msg);
		$display("Sequence error at time %0t: %s", $time, msg);
		errCount++;
		testErr = 1'b1;
	endtask

	task automatic finishCase(input string label);
		testCount++;
		$display("Case %0d %s: %s", testCount, label, testErr ? "mismatch" : "ok");
		testErr = 1'b0;
	endtask

	// Reset init and NPC = 4 up to the first fetch marEnable
	task automatic startupStep();
		if (pcClr && psrClr)
		begin
			sawClear = 1'b1;
			if (anyEnable)
				valueError("enable high while pcClr and psrClr are set");
		end
		if (npcEnable)
		begin
			npcPulses++;
			if (aluAMuxSelect != AluAZero || aluBMuxSelect != AluBFour)
				valueError($sformatf("NPC load with ALU selects %0d and %0d, expected 0 + 4",
					aluAMuxSelect, aluBMuxSelect));
		end
		if (irEnable || pcEnable || mdrEnable || regFileWrite || ramEnable || psrEnable)
			flowError("strobe other than npcEnable before the first fetch");
		if (marEnable)
		begin
			if (!sawClear || npcPulses != 1)
				valueError($sformatf("reset init saw clear %0b and %0d npcEnable pulses",
					sawClear, npcPulses));
			finishCase("reset init");
			startup = 1'b0;
			waitRam = 1'b1;
		end
	endtask

	task automatic fetchStep();
		if (pcClr || psrClr)
			valueError("pcClr or psrClr high outside reset init");
		if (ramEnable && ramOpCode != Op3Ld)
			valueError($sformatf("fetch ramOpCode %h, expected word read", ramOpCode));
		if (irEnable)
		begin
			if (!mfcSeen)
				flowError("irEnable came before mfc");
			word      = irOut; // Driven on the falling edge of this cycle
			idx       = 0;
			mfcSeen   = 1'b0;
			waitRam   = 1'b0;
			recording = 1'b1;
		end
		else if (mfcSeen)
		begin
			flowError("no irEnable in the cycle after mfc");
			mfcSeen = 1'b0;
		end
		else if (waitRam && !ramEnable)
		begin
			flowError("ramEnable dropped before mfc");
			waitRam = 1'b0;
		end
		if (marEnable)
			waitRam = 1'b1;
		if (ramEnable && mfc)
		begin
			mfcSeen = 1'b1;
			waitRam = 1'b0;
		end
	endtask

	task automatic executeStep();
		if (irEnable)
			flowError("second irEnable before the PC advance");
		if (pcClr || psrClr)
			valueError("pcClr or psrClr high outside reset init");
		if (pcEnable != npcEnable)
			valueError("pcEnable and npcEnable not paired");
		if (ramEnable && ramOpCode != word[Op3Hi:Op3Lo])
			valueError($sformatf("ramOpCode %h, expected op3 %h", ramOpCode, word[Op3Hi:Op3Lo]));
		if (obsKind != KindNone)
		begin
			expected = refEvent(word, idx);
			if (expected[87:44] == 44'd0)
				valueError($sformatf("unexpected strobe kind %0d as event %0d", obsKind, idx));
			else if ((obsWord & expected[87:44]) != expected[43:0])
				valueError($sformatf("event %0d is %h, expected %h under mask %h",
					idx, obsWord, expected[43:0], expected[87:44]));
			idx++;
			if (obsKind == KindPcAdv)
			begin
				finishCase($sformatf("word %h", word));
				recording = 1'b0;
			end
		end
	endtask

	// Samples at the rising edge with outputs settled from the previous cycle
	always @(posedge Clk)
	begin
		if (RESET)
		begin
			startup   = 1'b1;
			sawClear  = 1'b0;
			npcPulses = 0;
			waitRam   = 1'b0;
			mfcSeen   = 1'b0;
			recording = 1'b0;
			testErr   = 1'b0;
			testCount = 0;
			errCount  = 0;
		end
		else if (startup)
			startupStep();
		else if (!recording)
			fetchStep();
		else
			executeStep();
		ramPrev <= ramEnable; // Edge detect for RAM events
	end

endmodule

// File: tb/tbControlUnit.sv
module tbControlUnit
	import sparcIsaPkg::*;
	import ctrlPkg::*;
();

	localparam int WaitLimit = 100; // Cycles per strobe wait

	logic      Clk;
	logic      RESET;
	instrWordT irOut;
	logic      mfc;
	logic      irEnable;
	logic      npcEnable;
	logic      pcEnable;
	logic      mdrEnable;
	logic      marEnable;
	logic      regFileWrite;
	logic      ramEnable;
	logic      psrEnable;
	logic      pcClr;
	logic      psrClr;
	extSelT    extenderSelect;
	pcInSelT   pcInMuxSelect;
	aluASelT   aluAMuxSelect;
	psrSelT    psrMuxSelect;
	aluBSelT   aluBMuxSelect;
	logic      mdrMuxSelect;
	regAddrT   inPc;
	regAddrT   inPa;
	regAddrT   inPb;
	aluOpT     aluOp;
	op3T       ramOpCode;
	int        testCount;
	int        errCount;

	controlUnit i_controlUnit
	(
		.Clk            (Clk),
		.RESET          (RESET),
		.irOut          (irOut),
		.mfc            (mfc),
		.irEnable       (irEnable),
		.npcEnable      (npcEnable),
		.pcEnable       (pcEnable),
		.mdrEnable      (mdrEnable),
		.marEnable      (marEnable),
		.regFileWrite   (regFileWrite),
		.ramEnable      (ramEnable),
		.psrEnable      (psrEnable),
		.pcClr          (pcClr),
		.psrClr         (psrClr),
		.extenderSelect (extenderSelect),
		.pcInMuxSelect  (pcInMuxSelect),
		.aluAMuxSelect  (aluAMuxSelect),
		.psrMuxSelect   (psrMuxSelect),
		.aluBMuxSelect  (aluBMuxSelect),
		.mdrMuxSelect   (mdrMuxSelect),
		.inPc           (inPc),
		.inPa           (inPa),
		.inPb           (inPb),
		.aluOp          (aluOp),
		.ramOpCode      (ramOpCode)
	);

	ctrlChecker i_ctrlChecker
	(
		.Clk            (Clk),
		.RESET          (RESET),
		.irOut          (irOut),
		.mfc            (mfc),
		.irEnable       (irEnable),
		.npcEnable      (npcEnable),
		.pcEnable       (pcEnable),
		.mdrEnable      (mdrEnable),
		.marEnable      (marEnable),
		.regFileWrite   (regFileWrite),
		.ramEnable      (ramEnable),
		.psrEnable      (psrEnable),
		.pcClr          (pcClr),
		.psrClr         (psrClr),
		.extenderSelect (extenderSelect),
		.pcInMuxSelect  (pcInMuxSelect),
		.aluAMuxSelect  (aluAMuxSelect),
		.psrMuxSelect   (psrMuxSelect),
		.aluBMuxSelect  (aluBMuxSelect),
		.mdrMuxSelect   (mdrMuxSelect),
		.inPc           (inPc),
		.inPa           (inPa),
		.inPb           (inPb),
		.aluOp          (aluOp),
		.ramOpCode      (ramOpCode),
		.testCount      (testCount),
		.errCount       (errCount)
	);

	// Format 3 word with low13 as simm13 or {asi, rs2}
	function automatic instrWordT encodeFmt3(input logic [1:0] op, input regAddrT rd,
		input op3T op3, input regAddrT rs1, input logic i, input logic [12:0] low13);
		return {op, rd, op3, rs1, i, low13};
	endfunction

	function automatic instrWordT encodeSethi(input regAddrT rd, input logic [21:0] imm22);
		return {OpFmt2, rd, Op2Sethi, imm22};
	endfunction

	// Waits on falling edges for irEnable or the joint PC/NPC pulse
	task automatic awaitStrobe(input logic pcSide, output logic timedOut);
		int cycles;
		timedOut = 1'b1;
		for (cycles = 0; cycles < WaitLimit; cycles++)
		begin
			@(negedge Clk);
			if (pcSide ? (pcEnable && npcEnable) : irEnable)
			begin
				timedOut = 1'b0;
				break;
			end
		end
		if (timedOut)
			$display("Timeout: no %s within %0d cycles", pcSide ? "PC advance" : "irEnable",
				WaitLimit);
	endtask

	initial
	begin
		Clk = 1'b0;
		forever
			#5 Clk = ~Clk;
	end

	// Memory model with an mfc pulse 0 to 5 cycles after ramEnable
	initial
	begin : memResponder
		int delay;
		int seedDummy;
		mfc       = 1'b0;
		seedDummy = $urandom(32'h1eb2a23f);
		forever
		begin
			@(negedge Clk);
			if (ramEnable && !RESET)
			begin
				delay = $urandom_range(5, 0);
				repeat (delay) @(negedge Clk);
				mfc = 1'b1;
				@(negedge Clk);
				mfc = 1'b0;
			end
		end
	end

	initial
	begin : stimulus
		instrWordT instrList [$];
		logic      timedOut;
		int        k;
		RESET    = 1'b1;
		irOut    = '0;
		timedOut = 1'b0;
		instrList.push_back(encodeFmt3(OpArith, 5'd3, 6'h00, 5'd1, 1'b1, 13'd5));     // add imm
		instrList.push_back(encodeFmt3(OpArith, 5'd4, 6'h10, 5'd2, 1'b0, 13'd7));     // addcc reg
		instrList.push_back(encodeFmt3(OpArith, 5'd5, 6'h14, 5'd6, 1'b1, 13'h1fff));  // subcc -1
		instrList.push_back(encodeFmt3(OpArith, 5'd9, 6'h02, 5'd1, 1'b0, 13'd2));     // or reg
		instrList.push_back(encodeSethi(5'd10, 22'h12345));
		instrList.push_back(encodeFmt3(OpMem, 5'd11, Op3Ld, 5'd1, 1'b1, 13'd8));
		instrList.push_back(encodeFmt3(OpMem, 5'd12, Op3Ldub, 5'd2, 1'b0, 13'd3));
		instrList.push_back(encodeFmt3(OpMem, 5'd13, Op3Ldsh, 5'd4, 1'b1, 13'h1ffe));
		instrList.push_back(encodeFmt3(OpMem, 5'd17, Op3Lduh, 5'd18, 1'b0, 13'd19));
		instrList.push_back(encodeFmt3(OpMem, 5'd20, Op3Ldsb, 5'd21, 1'b1, 13'd1));
		instrList.push_back(encodeFmt3(OpMem, 5'd14, Op3St, 5'd5, 1'b1, 13'd4));
		instrList.push_back(encodeFmt3(OpMem, 5'd15, Op3Stb, 5'd6, 1'b0, 13'd7));
		instrList.push_back(encodeFmt3(OpMem, 5'd16, Op3Sth, 5'd8, 1'b1, 13'd0));
		instrList.push_back({OpFmt2, 1'b0, 4'b1000, 3'b010, 22'd16}); // Branch always
		instrList.push_back({OpCall, 30'd100});
		instrList.push_back(encodeFmt3(OpMem, 5'd2, 6'b000011, 5'd1, 1'b1, 13'd0)); // ldd
		repeat (2) @(negedge Clk);
		RESET = 1'b0;
		for (k = 0; k < instrList.size() && !timedOut; k++)
		begin
			awaitStrobe(1'b0, timedOut);
			if (!timedOut)
			begin
				irOut = instrList[k]; // IR holds it until the next irEnable
				awaitStrobe(1'b1, timedOut);
			end
		end
		repeat (2) @(negedge Clk); // Checker reports the last case
		$display("Cases run: %0d, errors: %0d", testCount, errCount);
		if (!timedOut && errCount == 0 && testCount == instrList.size() + 1)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: controlUnit.f
hdl/sparcIsaPkg.sv
hdl/ctrlPkg.sv
hdl/instrDecoder.sv
hdl/ctrlSequencer.sv
hdl/ctrlSignalGen.sv
hdl/controlUnit.sv
tb/ctrlChecker.sv
tb/tbControlUnit.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tbControlUnit -f controlUnit.f \
	-o simControlUnit \
	&& ./obj_dir/simControlUnit > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && { echo "Simulation reported failure"; exit 1; } \
	|| { echo "Simulation clean"; exit 0; }
